/* bench/despreadCorrelator_sva.sv */
`default_nettype none

module despreadCorrelatorSva (
    input wire                                 clk,
    input wire                                 reset,
    input wire                                 clkEn,
    input wire                                 onTime,
    input wire [despreadPkg::LengthBits-1:0]   corrLength,
    input wire [despreadPkg::DespreadBits-1:0] despread,
    input wire [despreadPkg::SyncBits-1:0]     syncCount
);

    timeunit 1ns;
    timeprecision 100ps;

    int failureCount = 0;

    // Bits below the kept field, per length
    function automatic logic [despreadPkg::DespreadBits-1:0] lowMask(
        input logic [despreadPkg::LengthBits-1:0] len
    );
        int zeros;
        if (len == 0) begin
            zeros = 10;
        end else if (len <= 2) begin
            zeros = 9;
        end else if (len <= 6) begin
            zeros = 8;
        end else if (len <= 14) begin
            zeros = 7;
        end else begin
            zeros = 6;
        end
        return (18'd1 << zeros) - 18'd1;
    endfunction

    syncBound: assert property (@(posedge clk) disable iff (reset)
        int'(syncCount) <= 4 * (int'(corrLength) + 1) - 1)
        else begin
            failureCount++;
            $error("syncCount above the pair count of the enabled groups");
        end

    lowBitsZero: assert property (@(posedge clk) disable iff (reset)
        (despread & lowMask(corrLength)) == '0)
        else begin
            failureCount++;
            $error("despread has bits set below the kept field");
        end

    // No capture and same length means nothing can move
    outputsHold: assert property (@(posedge clk) disable iff (reset)
        !(clkEn && !onTime) |=>
            ($stable(corrLength) -> ($stable(despread) && $stable(syncCount))))
        else begin
            failureCount++;
            $error("outputs changed without a capture strobe");
        end

endmodule

bind despreadCorrelator despreadCorrelatorSva despreadCorrelatorSva_inst (
    .clk        (clk),
    .reset      (reset),
    .clkEn      (clkEn),
    .onTime     (onTime),
    .corrLength (corrLength),
    .despread   (despread),
    .syncCount  (syncCount)
);

`default_nettype wire

/* bench/despreadTb.sv */
`default_nettype none

module despreadTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        clkEn = 1'b0;
    logic        onTime = 1'b0;
    logic        slip = 1'b0;
    logic        codeBit = 1'b0;
    logic [5:0]  rx = '0;
    logic [3:0]  corrLength = '0;
    wire  [17:0] despread;
    wire  [5:0]  syncCount;

    // Reference state
    int          mSample [64];
    int          mProd [64];
    logic [63:0] mCode;

    int          valueErrors = 0;
    int          otherErrors = 0;
    logic [31:0] rngState = 32'd89131;

    despreadCorrelator despreadCorrelator_inst (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .onTime     (onTime),
        .slip       (slip),
        .codeBit    (codeBit),
        .rx         (rx),
        .corrLength (corrLength),
        .despread   (despread),
        .syncCount  (syncCount)
    );

    always #2 clk = ~clk;

    // Hard limit on the whole run
    initial begin
        #80000;
        $display("Simulation limit reached before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int keptWidth(input int len);
        if (len == 0) return 8;
        if (len <= 2) return 9;
        if (len <= 6) return 10;
        if (len <= 14) return 11;
        return 12;
    endfunction

    // Each edge must arrive within two clock periods
    task automatic waitEdges(input int n);
        int  count;
        time start;
        count = 0;
        while (count < n) begin
            start = $time;
            fork
                @(posedge clk);
                #8;
            join_any
            disable fork;
            count++;
            if ($time - start >= 8) begin
                $display("No rising clock edge arrived within two clock periods");
                $display(">>> FAIL");
                $finish;
            end
        end
    endtask

    // One strobe on the DUT, mirrored in the reference state
    task automatic strobe(input logic en, input logic ot, input logic sl,
                          input logic cb, input logic [5:0] r);
        waitEdges(1);
        clkEn <= en;
        onTime <= ot;
        slip <= sl;
        codeBit <= cb;
        rx <= r;
        if (en && ot) begin
            for (int i = 63; i > 0; i--) begin
                mSample[i] = mSample[i-1];
            end
            mSample[0] = $signed(r);
            if (!sl) begin
                mCode = {mCode[62:0], cb};
            end
        end else if (en && !ot) begin
            for (int i = 0; i < 64; i++) begin
                mProd[i] = mCode[i] ? -mSample[i] : mSample[i];
            end
        end
    endtask

    task automatic applyReset();
        waitEdges(1);
        reset <= 1'b1;
        clkEn <= 1'b0;
        waitEdges(5);
        reset <= 1'b0;
        mCode = 64'd1;
        for (int i = 0; i < 64; i++) begin
            mProd[i] = 0;
        end
    endtask

    function automatic logic [17:0] modelDespread(input int len);
        int sum;
        int t;
        sum = 0;
        for (int i = 0; i < 64; i++) begin
            if (i / 4 <= len) sum += mProd[i];
        end
        t = sum & 2047;
        if (t >= 1024) t -= 2048;
        return 18'(t <<< (18 - keptWidth(len)));
    endfunction

    function automatic logic [5:0] modelSync(input int len);
        int n;
        n = 0;
        for (int i = 1; i < 64; i++) begin
            if (i / 4 <= len && ((mProd[i] < 0) != (mProd[i-1] < 0))) n++;
        end
        return 6'(n);
    endfunction

    // Called on a rising edge; outputs have settled one ns later
    task automatic checkOutputs(input string name, input logic [17:0] expD,
                                input logic [5:0] expS);
        #1;
        assert (despread === expD) else begin
            $display("error %s despread: expected %h, actual %h", name, expD, despread);
            valueErrors++;
        end
        assert (syncCount === expS) else begin
            $display("error %s syncCount: expected %0d, actual %0d", name, expS, syncCount);
            valueErrors++;
        end
    endtask

    // Capture, then one idle strobe during which the products update
    task automatic captureAndSettle(input logic [5:0] r);
        strobe(1'b1, 1'b0, 1'b0, 1'b0, r);
        strobe(1'b0, 1'b0, 1'b0, 1'b0, r);
    endtask

    task automatic runVectorFile();
        int          fd;
        int          got;
        int          len;
        int          slips;
        int          expSync;
        int          newLen;
        string       line;
        string       name;
        logic [5:0]  rxVal;
        logic [63:0] pattern;
        logic [17:0] expDesp;
        fd = $fopen("bench/despreadVectors.txt", "r");
        if (fd == 0) begin
            $display("Vector file bench/despreadVectors.txt could not be opened");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") continue;
            got = $sscanf(line, "%s %d %h %h %d %h %d", name, len, rxVal, pattern,
                          slips, expDesp, expSync);
            if (got != 7) begin
                $display("Malformed vector line: %s", line);
                otherErrors++;
                continue;
            end
            applyReset();
            corrLength <= 4'(len);
            for (int j = 0; j < 64; j++) begin
                strobe(1'b1, 1'b1, j < slips, pattern[63-j], rxVal);
                // Disabled strobes with junk inputs must leave no trace
                if (j % 16 == 7) begin
                    rngState = xorshift(rngState);
                    strobe(1'b0, j[4], rngState[0], rngState[1], rngState[7:2]);
                end
            end
            captureAndSettle(rxVal);
            checkOutputs(name, expDesp, 6'(expSync));
            // Length change alone, no new capture
            newLen = (len + 5) % 16;
            waitEdges(1);
            corrLength <= 4'(newLen);
            checkOutputs({name, "/lenChange"}, modelDespread(newLen), modelSync(newLen));
        end
        $fclose(fd);
    endtask

    task automatic runRandom(input int count);
        int len;
        for (int t = 0; t < count; t++) begin
            applyReset();
            rngState = xorshift(rngState);
            len = rngState[3:0];
            corrLength <= 4'(len);
            for (int j = 0; j < 64; j++) begin
                rngState = xorshift(rngState);
                strobe(1'b1, 1'b1, rngState[10:8] == 3'd0, rngState[6], rngState[5:0]);
                if (rngState[15:12] == 4'd0) begin
                    strobe(1'b0, rngState[16], 1'b0, rngState[17], rngState[23:18]);
                end
            end
            captureAndSettle(6'd0);
            checkOutputs($sformatf("random%0d", t), modelDespread(len), modelSync(len));
        end
    endtask

    initial begin
        int assertFailures;
        mCode = 64'd1;
        applyReset();
        corrLength <= 4'd15;
        waitEdges(2);
        checkOutputs("afterReset", 18'd0, 6'd0);
        runVectorFile();
        runRandom(12);
        waitEdges(2);
        assertFailures = despreadCorrelator_inst.despreadCorrelatorSva_inst.failureCount;
        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, assertFailures);
        if (valueErrors == 0 && otherErrors == 0 && assertFailures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/despreadVectors.txt */
# name corrLength rx(hex) code(hex, bit 63 shifted in first) slipCount
# expectedDespread(hex) expectedSyncCount(dec)
zeroCodeL0 0 05 0000000000000000 0 05000 0
onesCodeL3 3 05 FFFFFFFFFFFFFFFF 0 3B000 0
negRxL15 15 3D 0000000000000000 0 3D000 0
wrapL15 15 1F 0000000000000000 0 3F000 0
altCodeL1 1 07 AAAAAAAAAAAAAAAA 0 00000 7
altCodeL7 7 07 5555555555555555 0 00000 31
altCodeL15 15 3F AAAAAAAAAAAAAAAA 0 00000 63
slip4L15 15 02 0000000000000000 4 01F00 2
slip3L15 15 01 FFFFFFFFFFFFFFFF 3 3F100 1

/* hw/chipHistory.sv */
`default_nettype none

module chipHistory (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   clkEn,
    input  wire                                   onTime,
    input  wire                                   slip,
    input  wire                                   codeBit,
    input  wire [despreadPkg::SampleBits-1:0]     rx,
    output logic [despreadPkg::ChipCount-1:0][despreadPkg::SampleBits-1:0] samples,
    output logic [despreadPkg::ChipCount-1:0]     code
);

    logic shiftEn;

    assign shiftEn = clkEn && onTime;

    // Received samples, index 0 newest
    always_ff @(posedge clk) begin
        if (shiftEn) begin
            samples <= {samples[despreadPkg::ChipCount-2:0], rx};
        end
    end

    // Code holds on slip, moving it one chip against the samples
    always_ff @(posedge clk) begin
        if (reset) begin
            code <= {{(despreadPkg::ChipCount-1){1'b0}}, 1'b1};
        end else if (shiftEn && !slip) begin
            code <= {code[despreadPkg::ChipCount-2:0], codeBit};
        end
    end

endmodule

`default_nettype wire

/* hw/chipProducts.sv */
`default_nettype none

module chipProducts (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   clkEn,
    input  wire                                   onTime,
    input  wire [despreadPkg::ChipCount-1:0][despreadPkg::SampleBits-1:0] samples,
    input  wire [despreadPkg::ChipCount-1:0]      code,
    output logic [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0] products
);

    logic [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0] extended;
    logic [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0] flipped;

    always_comb begin
        for (int i = 0; i < despreadPkg::ChipCount; i++) begin
            extended[i] = {{(despreadPkg::SumBits-despreadPkg::SampleBits)
                            {samples[i][despreadPkg::SampleBits-1]}}, samples[i]};
            // Code bit one means the chip is inverted
            flipped[i] = code[i] ? -extended[i] : extended[i];
        end
    end

    // Captured on the enabled, off-time strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            products <= '0;
        end else if (clkEn && !onTime) begin
            products <= flipped;
        end
    end

endmodule

`default_nettype wire

/* hw/despreadCorrelator.sv */
`default_nettype none

module despreadCorrelator (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   clkEn,
    input  wire                                   onTime,
    input  wire                                   slip,
    input  wire                                   codeBit,
    input  wire [despreadPkg::SampleBits-1:0]     rx,
    input  wire [despreadPkg::LengthBits-1:0]     corrLength,
    output wire [despreadPkg::DespreadBits-1:0]   despread,
    output wire [despreadPkg::SyncBits-1:0]       syncCount
);

    wire [despreadPkg::ChipCount-1:0][despreadPkg::SampleBits-1:0] samples;
    wire [despreadPkg::ChipCount-1:0]                              code;
    wire [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0]    products;
    wire [despreadPkg::SumBits-1:0]                                total;

    chipHistory chipHistory_inst (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .onTime     (onTime),
        .slip       (slip),
        .codeBit    (codeBit),
        .rx         (rx),
        .samples    (samples),
        .code       (code)
    );

    chipProducts chipProducts_inst (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .onTime     (onTime),
        .samples    (samples),
        .code       (code),
        .products   (products)
    );

    groupAccumulator groupAccumulator_inst (
        .products   (products),
        .corrLength (corrLength),
        .total      (total)
    );

    despreadScaler despreadScaler_inst (
        .total      (total),
        .corrLength (corrLength),
        .despread   (despread)
    );

    // Sign changes between neighbouring chips, used for sync detection
    syncCounter syncCounter_inst (
        .products   (products),
        .corrLength (corrLength),
        .syncCount  (syncCount)
    );

endmodule

`default_nettype wire

/* hw/despreadPkg.sv */
`default_nettype none

package despreadPkg;

    localparam int ChipCount    = 64;
    localparam int GroupSize    = 4;
    localparam int GroupCount   = ChipCount / GroupSize;
    localparam int SampleBits   = 6;
    localparam int SumBits      = 11;
    localparam int LengthBits   = 4;
    localparam int DespreadBits = 18;
    localparam int SyncBits     = 6;

    // Low len+1 groups enabled
    function automatic logic [GroupCount-1:0] lengthMask(input logic [LengthBits-1:0] len);
        return ~({GroupCount{1'b1}} << (int'(len) + 1));
    endfunction

    // Extra integer bits kept above sample plus two
    function automatic int headroomBits(input logic [LengthBits-1:0] len);
        if (len == 0) begin
            return 0;
        end else if (len <= 2) begin
            return 1;
        end else if (len <= 6) begin
            return 2;
        end else if (len <= 14) begin
            return 3;
        end
        return 4;
    endfunction

endpackage

`default_nettype wire

/* hw/despreadScaler.sv */
`default_nettype none

module despreadScaler (
    input  wire [despreadPkg::SumBits-1:0]        total,
    input  wire [despreadPkg::LengthBits-1:0]     corrLength,
    output logic [despreadPkg::DespreadBits-1:0]  despread
);

    int                                   keptBits;
    logic [despreadPkg::DespreadBits-1:0] widened;

    assign keptBits = despreadPkg::SampleBits + 2 + despreadPkg::headroomBits(corrLength);

    // Sign extended, so a field wider than the total repeats its sign bit
    assign widened = {{(despreadPkg::DespreadBits-despreadPkg::SumBits)
                       {total[despreadPkg::SumBits-1]}}, total};

    // Low keptBits of the total land at the top, zeros below
    always_comb begin
        despread = widened << (despreadPkg::DespreadBits - keptBits);
    end

endmodule

`default_nettype wire

/* hw/groupAccumulator.sv */
`default_nettype none

module groupAccumulator (
    input  wire [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0] products,
    input  wire [despreadPkg::LengthBits-1:0]     corrLength,
    output logic [despreadPkg::SumBits-1:0]       total
);

    logic [despreadPkg::GroupCount-1:0]                          mask;
    logic [despreadPkg::GroupCount-1:0][despreadPkg::SumBits-1:0] groupSum;

    assign mask = despreadPkg::lengthMask(corrLength);

    // Sums of four consecutive products, zero beyond the length
    always_comb begin
        for (int g = 0; g < despreadPkg::GroupCount; g++) begin
            groupSum[g] = '0;
            if (mask[g]) begin
                for (int k = 0; k < despreadPkg::GroupSize; k++) begin
                    groupSum[g] = groupSum[g] + products[g*despreadPkg::GroupSize + k];
                end
            end
        end
    end

    // Wraps at the product width
    always_comb begin
        total = '0;
        for (int g = 0; g < despreadPkg::GroupCount; g++) begin
            total = total + groupSum[g];
        end
    end

endmodule

`default_nettype wire

/* hw/syncCounter.sv */
`default_nettype none

module syncCounter (
    input  wire [despreadPkg::ChipCount-1:0][despreadPkg::SumBits-1:0] products,
    input  wire [despreadPkg::LengthBits-1:0]     corrLength,
    output logic [despreadPkg::SyncBits-1:0]      syncCount
);

    logic [despreadPkg::GroupCount-1:0] mask;
    logic [despreadPkg::ChipCount-1:0]  signs;

    assign mask = despreadPkg::lengthMask(corrLength);

    always_comb begin
        for (int i = 0; i < despreadPkg::ChipCount; i++) begin
            signs[i] = products[i][despreadPkg::SumBits-1];
        end
    end

    // Pair (i-1, i) belongs to the group of product i
    always_comb begin
        syncCount = '0;
        for (int i = 1; i < despreadPkg::ChipCount; i++) begin
            if (mask[i / despreadPkg::GroupSize] && (signs[i] != signs[i-1])) begin
                syncCount = syncCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/despreadPkg.sv
hw/chipHistory.sv
hw/chipProducts.sv
hw/groupAccumulator.sv
hw/despreadScaler.sv
hw/syncCounter.sv
hw/despreadCorrelator.sv
bench/despreadCorrelator_sva.sv
bench/despreadTb.sv
